/* rtl/fir_pkg.sv */
package fir_pkg;

	localparam int unsigned SAMPLE_W   = 16;
	localparam int unsigned COEF_W     = 16;
	localparam int unsigned ACC_W      = 40;
	localparam int unsigned RESULT_W   = 24;
	localparam int unsigned REG_ADDR_W = 8;
	localparam int unsigned REG_DATA_W = 32;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0]   coef_t;
	// wide enough for 128 full-scale products
	typedef logic signed [ACC_W-1:0]    acc_t;
	typedef logic signed [RESULT_W-1:0] result_t;
	typedef logic [REG_ADDR_W-1:0]      reg_addr_t;
	typedef logic [REG_DATA_W-1:0]      reg_data_t;

	// arithmetic right shift of the tree sum before saturation
	localparam int unsigned OUT_SHIFT = 8;

	// register map, addresses below the limit select a tap
	localparam reg_addr_t REG_COEF_LIMIT = 8'h80;
	localparam reg_addr_t REG_OVERRIDE   = 8'h80;
	localparam reg_addr_t REG_LAST_Y     = 8'h81;
	localparam reg_addr_t REG_LAST_SHIFT = 8'h82;
	localparam reg_addr_t REG_COUNT      = 8'h83;

endpackage

/* rtl/coef_wr_if.sv */
`timescale 1ns/1ns

interface coef_wr_if;
	import fir_pkg::*;

	// single-cycle write pulse
	logic      we;
	reg_addr_t seg;
	reg_addr_t tap;
	coef_t     coef;

	modport src (output we, seg, tap, coef);
	modport dst (input we, seg, tap, coef);

endinterface

/* rtl/sample_intake.sv */
`timescale 1ns/1ns

module sample_intake (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             valid_strobe_i,
	input  fir_pkg::sample_t sample_i,
	input  logic             override_armed_i,
	input  fir_pkg::sample_t override_sample_i,
	output logic             override_taken_o,
	output logic             accept_o,
	output fir_pkg::sample_t sample_o
);
	import fir_pkg::*;

	logic strobe_q;
	logic strobe_rise;

	assign strobe_rise = valid_strobe_i && !strobe_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			strobe_q         <= 1'b0;
			accept_o         <= 1'b0;
			override_taken_o <= 1'b0;
		end else begin
			strobe_q         <= valid_strobe_i;
			accept_o         <= strobe_rise;
			// tells the register block to disarm
			override_taken_o <= strobe_rise && override_armed_i;
		end
	end

	// armed override wins over the pin sample
	always_ff @(posedge clk_i) begin
		if (strobe_rise) begin
			sample_o <= override_armed_i ? override_sample_i : sample_i;
		end
	end

endmodule

/* rtl/fir_regs.sv */
`timescale 1ns/1ns

module fir_regs #(
	parameter int unsigned TAPS_PER_SEG = 4
) (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               reg_we_i,
	input  fir_pkg::reg_addr_t reg_addr_i,
	input  fir_pkg::reg_data_t reg_wdata_i,
	output fir_pkg::reg_data_t reg_rdata_o,
	coef_wr_if.src             coef_wr,
	output logic               override_armed_o,
	output fir_pkg::sample_t   override_sample_o,
	input  logic               override_taken_i,
	input  logic               accept_i,
	input  fir_pkg::sample_t   last_shift_i,
	input  logic               result_valid_i,
	input  fir_pkg::result_t   result_i
);
	import fir_pkg::*;

	logic      ovr_we;
	result_t   last_y_q;
	sample_t   last_shift_q;
	reg_data_t count_q;

	// tap j lives in segment j / TAPS_PER_SEG
	assign coef_wr.we   = reg_we_i && (reg_addr_i < REG_COEF_LIMIT);
	assign coef_wr.seg  = reg_addr_t'(reg_addr_i / TAPS_PER_SEG);
	assign coef_wr.tap  = reg_addr_t'(reg_addr_i % TAPS_PER_SEG);
	assign coef_wr.coef = coef_t'(reg_wdata_i[COEF_W-1:0]);

	assign ovr_we = reg_we_i && (reg_addr_i == REG_OVERRIDE);

	// a fresh write re-arms even if the old value is taken now
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			override_armed_o <= 1'b0;
		end else if (ovr_we) begin
			override_armed_o <= 1'b1;
		end else if (override_taken_i) begin
			override_armed_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (ovr_we) begin
			override_sample_o <= sample_t'(reg_wdata_i[SAMPLE_W-1:0]);
		end
	end

	// readback state
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			last_y_q     <= '0;
			last_shift_q <= '0;
			count_q      <= '0;
		end else begin
			if (result_valid_i) begin
				last_y_q <= result_i;
			end
			if (accept_i) begin
				last_shift_q <= last_shift_i;
				count_q      <= count_q + 1'b1;
			end
		end
	end

	always_comb begin
		case (reg_addr_i)
			REG_LAST_Y:     reg_rdata_o = reg_data_t'(last_y_q);
			REG_LAST_SHIFT: reg_rdata_o = reg_data_t'(last_shift_q);
			REG_COUNT:      reg_rdata_o = count_q;
			default:        reg_rdata_o = '0;
		endcase
	end

endmodule

/* rtl/fir_segment.sv */
`timescale 1ns/1ns

module fir_segment #(
	parameter int unsigned TAPS_PER_SEG = 4,
	parameter int unsigned SEG_IDX      = 0
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	coef_wr_if.dst           coef_wr,
	input  logic             accept_i,
	input  fir_pkg::sample_t sample_i,
	output fir_pkg::sample_t shift_o,
	output logic             sum_valid_o,
	output fir_pkg::acc_t    sum_o
);
	import fir_pkg::*;

	sample_t dly_q [TAPS_PER_SEG];
	coef_t   coef_q [TAPS_PER_SEG];
	acc_t    mac_sum;
	logic    coef_hit;

	assign coef_hit = coef_wr.we && (coef_wr.seg == reg_addr_t'(SEG_IDX));
	// oldest entry, taken by the next segment before it moves
	assign shift_o  = dly_q[TAPS_PER_SEG-1];

	// products over the slice as it looks after the shift
	always_comb begin
		mac_sum = acc_t'(sample_i) * acc_t'(coef_q[0]);
		for (int k = 1; k < TAPS_PER_SEG; k++) begin
			mac_sum = mac_sum + acc_t'(dly_q[k-1]) * acc_t'(coef_q[k]);
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int k = 0; k < TAPS_PER_SEG; k++) begin
				dly_q[k]  <= '0;
				coef_q[k] <= '0;
			end
			sum_valid_o <= 1'b0;
		end else begin
			sum_valid_o <= accept_i;
			if (accept_i) begin
				dly_q[0] <= sample_i;
				for (int k = 1; k < TAPS_PER_SEG; k++) begin
					dly_q[k] <= dly_q[k-1];
				end
			end
			for (int k = 0; k < TAPS_PER_SEG; k++) begin
				if (coef_hit && (coef_wr.tap == reg_addr_t'(k))) begin
					coef_q[k] <= coef_wr.coef;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept_i) begin
			sum_o <= mac_sum;
		end
	end

endmodule

/* rtl/adder_tree.sv */
`timescale 1ns/1ns

module adder_tree #(
	parameter int unsigned NUM_SEG = 2
) (
	input  logic          clk_i,
	input  logic          rst_ni,
	input  logic          valid_i,
	input  fir_pkg::acc_t terms_i [NUM_SEG],
	output logic          valid_o,
	output fir_pkg::acc_t sum_o
);
	import fir_pkg::*;

	localparam int unsigned LEVELS = $clog2(NUM_SEG);

	if (NUM_SEG == 1) begin : g_single
		// nothing to add, just one register stage
		always_ff @(posedge clk_i or negedge rst_ni) begin
			if (!rst_ni) begin
				valid_o <= 1'b0;
			end else begin
				valid_o <= valid_i;
			end
		end

		always_ff @(posedge clk_i) begin
			sum_o <= terms_i[0];
		end
	end else begin : g_tree
		// heap order, node n adds nodes 2n+1 and 2n+2
		// indices from NUM_SEG-1 upward are the input terms
		acc_t             node_q [NUM_SEG-1];
		logic [LEVELS-1:0] vld_q;

		always_ff @(posedge clk_i or negedge rst_ni) begin
			if (!rst_ni) begin
				vld_q <= '0;
			end else begin
				vld_q[0] <= valid_i;
				for (int k = 1; k < LEVELS; k++) begin
					vld_q[k] <= vld_q[k-1];
				end
			end
		end

		always_ff @(posedge clk_i) begin
			for (int n = 0; n < NUM_SEG - 1; n++) begin
				if (2 * n + 1 >= NUM_SEG - 1) begin
					node_q[n] <= terms_i[2*n+1-(NUM_SEG-1)] + terms_i[2*n+2-(NUM_SEG-1)];
				end else begin
					node_q[n] <= node_q[2*n+1] + node_q[2*n+2];
				end
			end
		end

		assign valid_o = vld_q[LEVELS-1];
		assign sum_o   = node_q[0];
	end

endmodule

/* rtl/fir_output.sv */
`timescale 1ns/1ns

module fir_output (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             valid_i,
	input  fir_pkg::acc_t    sum_i,
	output logic             y_valid_o,
	output fir_pkg::result_t y_o
);
	import fir_pkg::*;

	localparam int unsigned RES_W = $bits(result_t);
	localparam acc_t Y_MAX = acc_t'(2 ** (RES_W - 1) - 1);
	localparam acc_t Y_MIN = -acc_t'(2 ** (RES_W - 1));

	acc_t    scaled;
	result_t y_sat;

	assign scaled = sum_i >>> OUT_SHIFT;

	// clamp to the result range
	always_comb begin
		if (scaled > Y_MAX) begin
			y_sat = result_t'(Y_MAX);
		end else if (scaled < Y_MIN) begin
			y_sat = result_t'(Y_MIN);
		end else begin
			y_sat = result_t'(scaled);
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			y_valid_o <= 1'b0;
		end else begin
			y_valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			y_o <= y_sat;
		end
	end

endmodule

/* rtl/fir_top.sv */
`timescale 1ns/1ns

module fir_top #(
	parameter int unsigned NUM_SEG      = 2,
	parameter int unsigned TAPS_PER_SEG = 4
) (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               valid_strobe_i,
	input  fir_pkg::sample_t   sample_i,
	input  logic               reg_we_i,
	input  fir_pkg::reg_addr_t reg_addr_i,
	input  fir_pkg::reg_data_t reg_wdata_i,
	output fir_pkg::reg_data_t reg_rdata_o,
	output logic               y_valid_o,
	output fir_pkg::result_t   y_o
);
	import fir_pkg::*;

	logic    accept;
	logic    ovr_armed;
	sample_t ovr_sample;
	logic    ovr_taken;
	// chain[0] is the intake sample, chain[NUM_SEG] falls out of the end
	sample_t chain [NUM_SEG+1];
	acc_t    seg_sum [NUM_SEG];
	logic [NUM_SEG-1:0] seg_valid;
	logic    tree_valid;
	acc_t    tree_sum;

	coef_wr_if coef_wr ();

	sample_intake u_intake (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.valid_strobe_i    (valid_strobe_i),
		.sample_i          (sample_i),
		.override_armed_i  (ovr_armed),
		.override_sample_i (ovr_sample),
		.override_taken_o  (ovr_taken),
		.accept_o          (accept),
		.sample_o          (chain[0])
	);

	fir_regs #(
		.TAPS_PER_SEG (TAPS_PER_SEG)
	) u_regs (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.reg_we_i          (reg_we_i),
		.reg_addr_i        (reg_addr_i),
		.reg_wdata_i       (reg_wdata_i),
		.reg_rdata_o       (reg_rdata_o),
		.coef_wr           (coef_wr.src),
		.override_armed_o  (ovr_armed),
		.override_sample_o (ovr_sample),
		.override_taken_i  (ovr_taken),
		.accept_i          (accept),
		.last_shift_i      (chain[NUM_SEG]),
		.result_valid_i    (y_valid_o),
		.result_i          (y_o)
	);

	for (genvar g = 0; g < NUM_SEG; g++) begin : g_seg
		fir_segment #(
			.TAPS_PER_SEG (TAPS_PER_SEG),
			.SEG_IDX      (g)
		) u_seg (
			.clk_i       (clk_i),
			.rst_ni      (rst_ni),
			.coef_wr     (coef_wr.dst),
			.accept_i    (accept),
			.sample_i    (chain[g]),
			.shift_o     (chain[g+1]),
			.sum_valid_o (seg_valid[g]),
			.sum_o       (seg_sum[g])
		);
	end

	// all segments fire together
	adder_tree #(
		.NUM_SEG (NUM_SEG)
	) u_tree (
		.clk_i   (clk_i),
		.rst_ni  (rst_ni),
		.valid_i (&seg_valid),
		.terms_i (seg_sum),
		.valid_o (tree_valid),
		.sum_o   (tree_sum)
	);

	fir_output u_out (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.valid_i   (tree_valid),
		.sum_i     (tree_sum),
		.y_valid_o (y_valid_o),
		.y_o       (y_o)
	);

endmodule

/* bench/fir_properties.sv */
`timescale 1ns/1ns

module fir_properties #(
	parameter int unsigned LATENCY = 4
) (
	input logic clk_i,
	input logic rst_ni,
	input logic strobe_i,
	input logic y_valid_i
);

	// count of failed assertions
	int unsigned failures = 0;

	// result strobe is a single-cycle pulse
	y_valid_single: assert property (
		@(posedge clk_i) disable iff (!rst_ni) y_valid_i |=> !y_valid_i
	) else begin
		failures++;
		$error("y_valid_o stayed high for more than one cycle");
	end

	// fixed latency from the strobe edge to the result
	strobe_to_result: assert property (
		@(posedge clk_i) disable iff (!rst_ni) $rose(strobe_i) |-> ##LATENCY y_valid_i
	) else begin
		failures++;
		$error("no result strobe %0d cycles after a sample strobe", LATENCY);
	end

	y_valid_in_reset: assert property (
		@(posedge clk_i) !rst_ni |-> !y_valid_i
	) else begin
		failures++;
		$error("y_valid_o high during reset");
	end

endmodule

bind fir_top fir_properties u_props (
	.clk_i     (clk_i),
	.rst_ni    (rst_ni),
	.strobe_i  (valid_strobe_i),
	.y_valid_i (y_valid_o)
);

/* bench/fir_tb.sv */
`timescale 1ns/1ns

module fir_tb;
	import fir_pkg::*;

	localparam string STIM_FILE = "bench/fir_stim.txt";

	logic      clk = 1'b0;
	logic      rst_n;
	logic      strobe;
	sample_t   sample;
	logic      reg_we;
	reg_addr_t reg_addr;
	reg_data_t reg_wdata;
	reg_data_t reg_rdata;
	logic      y_valid;
	result_t   y;

	// expected results, oldest first
	int exp_q [$];
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	fir_top #(
		.NUM_SEG      (2),
		.TAPS_PER_SEG (4)
	) uut (
		.clk_i          (clk),
		.rst_ni         (rst_n),
		.valid_strobe_i (strobe),
		.sample_i       (sample),
		.reg_we_i       (reg_we),
		.reg_addr_i     (reg_addr),
		.reg_wdata_i    (reg_wdata),
		.reg_rdata_o    (reg_rdata),
		.y_valid_o      (y_valid),
		.y_o            (y)
	);

	always #4 clk = ~clk;

	task automatic check_equal(input string what, input logic signed [31:0] actual,
			input logic signed [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic report_bad_line(input string text);
		errors++;
		$display("malformed stimulus line: %s", text);
	endtask

	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		@(posedge clk);
		reg_we    <= 1'b1;
		reg_addr  <= addr;
		reg_wdata <= data;
		@(posedge clk);
		reg_we    <= 1'b0;
	endtask

	// strobe high for one cycle, then low for one
	task automatic send_sample(input sample_t value);
		@(posedge clk);
		strobe <= 1'b1;
		sample <= value;
		@(posedge clk);
		strobe <= 1'b0;
	endtask

	task automatic wait_for_results();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic read_check(input reg_addr_t addr, input int expected);
		// readback must see every result already out
		wait_for_results();
		@(posedge clk);
		reg_addr <= addr;
		@(negedge clk);
		check_equal($sformatf("register 0x%02h", addr), reg_rdata, expected);
	endtask

	// each result strobe takes the oldest expected value
	always @(negedge clk) begin
		if (rst_n && y_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("result strobe at %0t ns while no result was expected", $time);
			end else begin
				check_equal("y_o", y, exp_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int        fd;
		int        n;
		int        lines;
		int        value;
		byte       op;
		reg_addr_t addr;
		string     line;

		rst_n     = 1'b0;
		strobe    = 1'b0;
		sample    = '0;
		reg_we    = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;

		// first pass only sizes the timeout
		lines = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) > 0) begin
				lines++;
			end
			$fclose(fd);
		end
		cycle_limit = 2 * lines * 4 + 100;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file %s", STIM_FILE);
		end else begin
			while ($fgets(line, fd) > 0) begin
				n = $sscanf(line, "%c", op);
				case (op)
					"C": begin
						n = $sscanf(line, "%c %h %d", op, addr, value);
						if (n == 3) begin
							write_reg(addr, reg_data_t'(value));
						end else begin
							report_bad_line(line);
						end
					end
					"O": begin
						n = $sscanf(line, "%c %d", op, value);
						if (n == 2) begin
							write_reg(REG_OVERRIDE, reg_data_t'(value));
						end else begin
							report_bad_line(line);
						end
					end
					"S": begin
						n = $sscanf(line, "%c %d", op, value);
						if (n == 2) begin
							send_sample(sample_t'(value));
						end else begin
							report_bad_line(line);
						end
					end
					"E": begin
						n = $sscanf(line, "%c %d", op, value);
						if (n == 2) begin
							exp_q.push_back(value);
						end else begin
							report_bad_line(line);
						end
					end
					"R": begin
						n = $sscanf(line, "%c %h %d", op, addr, value);
						if (n == 3) begin
							read_check(addr, value);
						end else begin
							report_bad_line(line);
						end
					end
					"#", "\n", "\r": begin
						// comment or blank line
					end
					default: begin
						errors++;
						$display("unknown operation in stimulus line: %s", line);
					end
				endcase
			end
			$fclose(fd);
		end

		wait_for_results();
		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			uut.u_props.failures);
		if (errors == 0 && uut.u_props.failures == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* all.f */
rtl/fir_pkg.sv
rtl/coef_wr_if.sv
rtl/sample_intake.sv
rtl/fir_regs.sv
rtl/fir_segment.sv
rtl/adder_tree.sv
rtl/fir_output.sv
rtl/fir_top.sv
bench/fir_properties.sv
bench/fir_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fir_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/fir_stim.txt */
# one operation per line, addresses in hex, data in signed decimal
# C addr coef | O sample | S sample | E result | R addr value
C 00 16
C 01 32
C 02 -16
C 03 64
C 04 256
C 05 -128
C 06 8
C 07 1
S 256
E 16
S 0
E 32
S 0
E -16
S 0
E 64
S 0
E 256
S 0
E -128
S 0
E 8
S 0
E 1
S 1000
E 62
R 82 256
S 1000
E 187
S 1000
E 125
S -3000
E 125
S 500
E 843
S -7
E 999
S 12345
E 520
S -20000
E -3047
C 00 -32768
C 01 -32768
C 02 -32768
S -32768
E 5176177
S -32768
E 8388607
S 32767
E 4201784
S 32767
E -4228411
S 32767
E -8388608
R 81 -8388608
C 00 256
C 01 0
C 02 0
O 100
S 9999
E -8670
S 200
E 56440
R 81 56440
R 82 12345
R 83 23
